// ==== Makefile ====
TOP = soc_bus_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f soc_bus.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f soc_bus.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qF 'All tests passed!'

clean:
	rm -rf obj_dir

// ==== soc_bus.f ====
source/soc_bus_pkg.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/tim_ram.sv
source/clint.sv
source/uart_tx.sv
source/soc_bus.sv
testbench/soc_bus_tb.sv

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                imem_valid,
  input  logic [soc_bus_pkg::addr_width-1:0]  imem_addr,
  output logic                                imem_ready,
  output logic [soc_bus_pkg::data_width-1:0]  imem_rdata,
  output logic                                imem_error,
  input  logic                                dmem_valid,
  input  logic [soc_bus_pkg::addr_width-1:0]  dmem_addr,
  input  logic [soc_bus_pkg::data_width-1:0]  dmem_wdata,
  input  logic [soc_bus_pkg::strb_width-1:0]  dmem_wstrb,
  output logic                                dmem_ready,
  output logic [soc_bus_pkg::data_width-1:0]  dmem_rdata,
  output logic                                dmem_error,
  output logic                                bus_valid,
  output logic [soc_bus_pkg::addr_width-1:0]  bus_addr,
  output logic [soc_bus_pkg::data_width-1:0]  bus_wdata,
  output logic [soc_bus_pkg::strb_width-1:0]  bus_wstrb,
  input  logic                                bus_ready,
  input  logic [soc_bus_pkg::data_width-1:0]  bus_rdata,
  input  logic                                bus_error
);

  logic busy;  // a transaction is out on the bus
  logic grant_data;  // owner of the current or last transaction, 1 for the data port
  logic pick_data;
  logic any_pending;

  logic [soc_bus_pkg::addr_width-1:0] req_addr;
  logic [soc_bus_pkg::data_width-1:0] req_wdata;
  logic [soc_bus_pkg::strb_width-1:0] req_wstrb;

  assign any_pending = imem_valid | dmem_valid;

  always_comb begin
    if (imem_valid & dmem_valid) begin
      pick_data = ~grant_data;  // round robin, the port not served last goes first
    end else begin
      pick_data = dmem_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      busy <= 1'b0;
      grant_data <= 1'b0;
    end else if (busy == 1'b0) begin
      if (any_pending) begin
        busy <= 1'b1;
        grant_data <= pick_data;
      end
    end else if (bus_ready) begin
      busy <= 1'b0;  // forces one idle cycle before the next grant
    end
  end

  always_ff @(posedge clock) begin
    if (busy == 1'b0) begin
      if (pick_data) begin
        req_addr <= dmem_addr;
        req_wdata <= dmem_wdata;
        req_wstrb <= dmem_wstrb;
      end else begin
        req_addr <= imem_addr;
        req_wdata <= '0;
        req_wstrb <= '0;  // instruction fetches are always reads
      end
    end
  end

  assign bus_valid = busy;
  assign bus_addr = req_addr;
  assign bus_wdata = req_wdata;
  assign bus_wstrb = req_wstrb;

  // only the owning port sees the ready pulse
  assign imem_ready = busy & ~grant_data & bus_ready;
  assign dmem_ready = busy & grant_data & bus_ready;

  assign imem_rdata = bus_rdata;
  assign imem_error = bus_error;
  assign dmem_rdata = bus_rdata;
  assign dmem_error = bus_error;

endmodule

// ==== source/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                bus_valid,
  input  logic [soc_bus_pkg::addr_width-1:0]  bus_addr,
  input  logic [soc_bus_pkg::data_width-1:0]  bus_wdata,
  input  logic [soc_bus_pkg::strb_width-1:0]  bus_wstrb,
  output logic                                bus_ready,
  output logic [soc_bus_pkg::data_width-1:0]  bus_rdata,
  output logic                                bus_error,
  output logic                                tim_valid,
  output logic [soc_bus_pkg::addr_width-1:0]  tim_addr,
  output logic [soc_bus_pkg::data_width-1:0]  tim_wdata,
  output logic [soc_bus_pkg::strb_width-1:0]  tim_wstrb,
  input  logic                                tim_ready,
  input  logic [soc_bus_pkg::data_width-1:0]  tim_rdata,
  output logic                                clint_valid,
  output logic [soc_bus_pkg::addr_width-1:0]  clint_addr,
  output logic [soc_bus_pkg::data_width-1:0]  clint_wdata,
  output logic [soc_bus_pkg::strb_width-1:0]  clint_wstrb,
  input  logic                                clint_ready,
  input  logic [soc_bus_pkg::data_width-1:0]  clint_rdata,
  output logic                                uart_valid,
  output logic [soc_bus_pkg::addr_width-1:0]  uart_addr,
  output logic [soc_bus_pkg::data_width-1:0]  uart_wdata,
  output logic [soc_bus_pkg::strb_width-1:0]  uart_wstrb,
  input  logic                                uart_ready,
  input  logic [soc_bus_pkg::data_width-1:0]  uart_rdata
);

  logic tim_hit;
  logic clint_hit;
  logic uart_hit;
  logic error_valid;
  logic error_ready;  // the error responder's one-cycle answer
  logic [soc_bus_pkg::addr_width-1:0] base_addr;
  logic [soc_bus_pkg::addr_width-1:0] local_addr;

  // a region matches when the address without its mask bits equals the base
  assign tim_hit = (bus_addr & ~soc_bus_pkg::tim_mask_addr) == soc_bus_pkg::tim_base_addr;
  assign clint_hit = (bus_addr & ~soc_bus_pkg::clint_mask_addr) == soc_bus_pkg::clint_base_addr;
  assign uart_hit = (bus_addr & ~soc_bus_pkg::uart_tx_mask_addr) ==
                    soc_bus_pkg::uart_tx_base_addr;

  always_comb begin
    base_addr = '0;
    if (tim_hit) base_addr = soc_bus_pkg::tim_base_addr;
    if (clint_hit) base_addr = soc_bus_pkg::clint_base_addr;
    if (uart_hit) base_addr = soc_bus_pkg::uart_tx_base_addr;
  end

  assign local_addr = bus_addr - base_addr;

  assign tim_valid = bus_valid & tim_hit;
  assign clint_valid = bus_valid & clint_hit;
  assign uart_valid = bus_valid & uart_hit;
  assign error_valid = bus_valid & ~(tim_hit | clint_hit | uart_hit);

  assign tim_addr = local_addr;
  assign clint_addr = local_addr;
  assign uart_addr = local_addr;
  assign tim_wdata = bus_wdata;
  assign clint_wdata = bus_wdata;
  assign uart_wdata = bus_wdata;
  assign tim_wstrb = bus_wstrb;
  assign clint_wstrb = bus_wstrb;
  assign uart_wstrb = bus_wstrb;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      error_ready <= 1'b0;
    end else begin
      error_ready <= error_valid & ~error_ready;  // pulse once per request
    end
  end

  always_comb begin
    bus_rdata = '0;  // the error responder returns zero data
    if (tim_ready) bus_rdata = tim_rdata;
    if (clint_ready) bus_rdata = clint_rdata;
    if (uart_ready) bus_rdata = uart_rdata;
  end

  assign bus_ready = tim_ready | clint_ready | uart_ready | error_ready;
  assign bus_error = error_ready;

endmodule

// ==== source/clint.sv ====
`timescale 1ns/1ps

module clint (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                mem_valid,
  input  logic [soc_bus_pkg::addr_width-1:0]  mem_addr,
  input  logic [soc_bus_pkg::data_width-1:0]  mem_wdata,
  input  logic [soc_bus_pkg::strb_width-1:0]  mem_wstrb,
  output logic                                mem_ready,
  output logic [soc_bus_pkg::data_width-1:0]  mem_rdata,
  output logic                                msip,
  output logic                                mtip
);

  logic [$clog2(soc_bus_pkg::clint_tick_cycles)-1:0] tick_count;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic msip_bit;
  logic access;
  logic write;

  function automatic logic [soc_bus_pkg::data_width-1:0] merge_bytes(
    input logic [soc_bus_pkg::data_width-1:0] old_word,
    input logic [soc_bus_pkg::data_width-1:0] new_word,
    input logic [soc_bus_pkg::strb_width-1:0] strb
  );
    logic [soc_bus_pkg::data_width-1:0] result;
    result = old_word;
    for (int i = 0; i < soc_bus_pkg::strb_width; i++) begin
      if (strb[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  assign access = mem_valid & ~mem_ready;
  assign write = access & (|mem_wstrb);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      tick_count <= '0;
      mtime <= '0;
    end else if (tick_count ==
                 ($clog2(soc_bus_pkg::clint_tick_cycles))'(soc_bus_pkg::clint_tick_cycles - 1)) begin
      tick_count <= '0;
      mtime <= mtime + 64'd1;
    end else begin
      tick_count <= tick_count + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      mem_ready <= 1'b0;
      msip_bit <= 1'b0;
      mtimecmp <= '1;  // no timer interrupt until software programs a compare value
    end else begin
      mem_ready <= access;
      if (write) begin
        case (mem_addr[15:0])
          16'h0000: if (mem_wstrb[0]) msip_bit <= mem_wdata[0];
          16'h4000: mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], mem_wdata, mem_wstrb);
          16'h4004: mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], mem_wdata, mem_wstrb);
          default: ;  // mtime is read-only
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      case (mem_addr[15:0])
        16'h0000: mem_rdata <= {31'b0, msip_bit};
        16'h4000: mem_rdata <= mtimecmp[31:0];
        16'h4004: mem_rdata <= mtimecmp[63:32];
        16'hBFF8: mem_rdata <= mtime[31:0];
        16'hBFFC: mem_rdata <= mtime[63:32];
        default: mem_rdata <= '0;
      endcase
    end
  end

  assign msip = msip_bit;
  assign mtip = mtime >= mtimecmp;

endmodule

// ==== source/soc_bus.sv ====
`timescale 1ns/1ps

module soc_bus (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                imem_valid,
  input  logic [soc_bus_pkg::addr_width-1:0]  imem_addr,
  output logic                                imem_ready,
  output logic [soc_bus_pkg::data_width-1:0]  imem_rdata,
  output logic                                imem_error,
  input  logic                                dmem_valid,
  input  logic [soc_bus_pkg::addr_width-1:0]  dmem_addr,
  input  logic [soc_bus_pkg::data_width-1:0]  dmem_wdata,
  input  logic [soc_bus_pkg::strb_width-1:0]  dmem_wstrb,
  output logic                                dmem_ready,
  output logic [soc_bus_pkg::data_width-1:0]  dmem_rdata,
  output logic                                dmem_error,
  output logic                                tx,
  output logic                                msip,
  output logic                                mtip
);

  logic                               bus_valid;
  logic [soc_bus_pkg::addr_width-1:0] bus_addr;
  logic [soc_bus_pkg::data_width-1:0] bus_wdata;
  logic [soc_bus_pkg::strb_width-1:0] bus_wstrb;
  logic                               bus_ready;
  logic [soc_bus_pkg::data_width-1:0] bus_rdata;
  logic                               bus_error;

  logic                               tim_valid;
  logic [soc_bus_pkg::addr_width-1:0] tim_addr;
  logic [soc_bus_pkg::data_width-1:0] tim_wdata;
  logic [soc_bus_pkg::strb_width-1:0] tim_wstrb;
  logic                               tim_ready;
  logic [soc_bus_pkg::data_width-1:0] tim_rdata;

  logic                               clint_valid;
  logic [soc_bus_pkg::addr_width-1:0] clint_addr;
  logic [soc_bus_pkg::data_width-1:0] clint_wdata;
  logic [soc_bus_pkg::strb_width-1:0] clint_wstrb;
  logic                               clint_ready;
  logic [soc_bus_pkg::data_width-1:0] clint_rdata;

  logic                               uart_valid;
  logic [soc_bus_pkg::addr_width-1:0] uart_addr;
  logic [soc_bus_pkg::data_width-1:0] uart_wdata;
  logic [soc_bus_pkg::strb_width-1:0] uart_wstrb;
  logic                               uart_ready;
  logic [soc_bus_pkg::data_width-1:0] uart_rdata;

  bus_arbiter arbiter0 (
    .clock(clock), .reset(reset),
    .imem_valid(imem_valid), .imem_addr(imem_addr),
    .imem_ready(imem_ready), .imem_rdata(imem_rdata), .imem_error(imem_error),
    .dmem_valid(dmem_valid), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb),
    .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata), .dmem_error(dmem_error),
    .bus_valid(bus_valid), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_wstrb(bus_wstrb),
    .bus_ready(bus_ready), .bus_rdata(bus_rdata), .bus_error(bus_error)
  );

  bus_decoder decoder0 (
    .clock(clock), .reset(reset),
    .bus_valid(bus_valid), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_wstrb(bus_wstrb),
    .bus_ready(bus_ready), .bus_rdata(bus_rdata), .bus_error(bus_error),
    .tim_valid(tim_valid), .tim_addr(tim_addr),
    .tim_wdata(tim_wdata), .tim_wstrb(tim_wstrb),
    .tim_ready(tim_ready), .tim_rdata(tim_rdata),
    .clint_valid(clint_valid), .clint_addr(clint_addr),
    .clint_wdata(clint_wdata), .clint_wstrb(clint_wstrb),
    .clint_ready(clint_ready), .clint_rdata(clint_rdata),
    .uart_valid(uart_valid), .uart_addr(uart_addr),
    .uart_wdata(uart_wdata), .uart_wstrb(uart_wstrb),
    .uart_ready(uart_ready), .uart_rdata(uart_rdata)
  );

  tim_ram tim0 (
    .clock(clock), .reset(reset),
    .mem_valid(tim_valid), .mem_addr(tim_addr),
    .mem_wdata(tim_wdata), .mem_wstrb(tim_wstrb),
    .mem_ready(tim_ready), .mem_rdata(tim_rdata)
  );

  clint clint0 (
    .clock(clock), .reset(reset),
    .mem_valid(clint_valid), .mem_addr(clint_addr),
    .mem_wdata(clint_wdata), .mem_wstrb(clint_wstrb),
    .mem_ready(clint_ready), .mem_rdata(clint_rdata),
    .msip(msip), .mtip(mtip)
  );

  uart_tx uart0 (
    .clock(clock), .reset(reset),
    .mem_valid(uart_valid), .mem_addr(uart_addr),
    .mem_wdata(uart_wdata), .mem_wstrb(uart_wstrb),
    .mem_ready(uart_ready), .mem_rdata(uart_rdata),
    .tx(tx)
  );

endmodule

// ==== source/soc_bus_pkg.sv ====
package soc_bus_pkg;

  // bus widths shared by the masters, the arbiter and every slave
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  // tightly integrated memory, 4 KiB of words
  localparam logic [addr_width-1:0] tim_base_addr = 32'h8000_0000;
  localparam logic [addr_width-1:0] tim_mask_addr = 32'h0000_0FFF;

  // core-local interruptor, standard 64 KiB window
  localparam logic [addr_width-1:0] clint_base_addr = 32'h0200_0000;
  localparam logic [addr_width-1:0] clint_mask_addr = 32'h0000_FFFF;

  // UART transmitter, data at offset 0 and status at offset 4
  localparam logic [addr_width-1:0] uart_tx_base_addr = 32'h1000_0000;
  localparam logic [addr_width-1:0] uart_tx_mask_addr = 32'h0000_000F;

  localparam int tim_depth = 1024;  // words, must fill the tim window

  // clock dividers
  localparam int clint_tick_cycles = 4;  // clocks per mtime increment
  localparam int uart_bit_cycles = 8;  // clocks per serial bit

endpackage

// ==== source/tim_ram.sv ====
`timescale 1ns/1ps

module tim_ram (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                mem_valid,
  input  logic [soc_bus_pkg::addr_width-1:0]  mem_addr,
  input  logic [soc_bus_pkg::data_width-1:0]  mem_wdata,
  input  logic [soc_bus_pkg::strb_width-1:0]  mem_wstrb,
  output logic                                mem_ready,
  output logic [soc_bus_pkg::data_width-1:0]  mem_rdata
);

  logic [soc_bus_pkg::data_width-1:0] ram [soc_bus_pkg::tim_depth];
  logic [$clog2(soc_bus_pkg::tim_depth)-1:0] word_index;
  logic access;

  // byte address to word index
  assign word_index = mem_addr[$clog2(soc_bus_pkg::tim_depth)+1:2];

  // the request is still held during the ready cycle, so it must not count twice
  assign access = mem_valid & ~mem_ready;

  always_ff @(posedge clock) begin
    if (access) begin
      for (int i = 0; i < soc_bus_pkg::strb_width; i++) begin
        if (mem_wstrb[i]) begin
          ram[word_index][8*i +: 8] <= mem_wdata[8*i +: 8];
        end
      end
      if (|mem_wstrb) begin
        mem_rdata <= '0;  // writes answer with zero data
      end else begin
        mem_rdata <= ram[word_index];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= access;
    end
  end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                mem_valid,
  input  logic [soc_bus_pkg::addr_width-1:0]  mem_addr,
  input  logic [soc_bus_pkg::data_width-1:0]  mem_wdata,
  input  logic [soc_bus_pkg::strb_width-1:0]  mem_wstrb,
  output logic                                mem_ready,
  output logic [soc_bus_pkg::data_width-1:0]  mem_rdata,
  output logic                                tx
);

  logic busy;
  logic [9:0] frame;  // stop bit, data, start bit, shifted out from bit 0
  logic [3:0] bit_count;
  logic [$clog2(soc_bus_pkg::uart_bit_cycles)-1:0] cycle_count;
  logic data_write;
  logic accept;
  logic bit_done;

  assign data_write = mem_valid & (|mem_wstrb) & (mem_addr[3:2] == 2'd0);

  // a data write has to wait for the line while a frame is still going out
  assign accept = mem_valid & ~mem_ready & ~(data_write & busy);

  assign bit_done = cycle_count ==
                    ($clog2(soc_bus_pkg::uart_bit_cycles))'(soc_bus_pkg::uart_bit_cycles - 1);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      busy <= 1'b0;
      frame <= '1;  // idle line is high
      bit_count <= '0;
      cycle_count <= '0;
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= accept;
      if (accept & data_write) begin
        busy <= 1'b1;
        frame <= {1'b1, mem_wdata[7:0], 1'b0};
        bit_count <= '0;
        cycle_count <= '0;
      end else if (busy) begin
        if (bit_done) begin
          cycle_count <= '0;
          frame <= {1'b1, frame[9:1]};
          if (bit_count == 4'd9) begin
            busy <= 1'b0;  // stop bit finished
          end else begin
            bit_count <= bit_count + 4'd1;
          end
        end else begin
          cycle_count <= cycle_count + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      if (mem_addr[3:2] == 2'd1) begin
        mem_rdata <= {31'b0, busy};  // status, bit 0 is busy
      end else begin
        mem_rdata <= '0;
      end
    end
  end

  assign tx = frame[0];

endmodule

// ==== testbench/bus_patterns.txt ====
// port (0 instruction, 1 data), address, write data, strobe, expected rdata, expected error
// a zero strobe is a read, and unmapped requests expect error 1 with rdata 0
1 80000000 11223344 f 00000000 0
1 80000004 aabbccdd f 00000000 0
1 80000004 00005500 2 00000000 0
1 80000008 cafef00d f 00000000 0
1 80000008 12345678 c 00000000 0
0 80000000 00000000 0 11223344 0
1 80000004 00000000 0 aabb55dd 0
0 80000008 00000000 0 1234f00d 0
1 80000ffc 0badc0de f 00000000 0
1 40000000 deadbeef f 00000000 1
0 00000100 00000000 0 00000000 1
1 80000ffc 00000000 0 0badc0de 0
0 80000004 00000000 0 aabb55dd 0
1 80000010 01020304 f 00000000 0
0 80000000 00000000 0 11223344 0
1 80000010 00000000 0 01020304 0
0 80000ffc 00000000 0 0badc0de 0
1 80000010 000000ff 1 00000000 0
0 80000008 00000000 0 1234f00d 0
1 80000010 00000000 0 010203ff 0
0 10000100 00000000 0 00000000 1
1 80001000 00000000 0 00000000 1
0 80000010 00000000 0 010203ff 0
1 02004004 00000000 0 ffffffff 0
0 02000000 00000000 0 00000000 0

// ==== testbench/soc_bus_tb.sv ====
`timescale 1ns/1ps

module soc_bus_tb;

  localparam int seed = 20993;
  localparam int clock_period = 8;
  localparam int pattern_count = 25;
  localparam int timeout_cycles = pattern_count * 200 + 2000;

  logic                               clock;
  logic                               reset;
  logic                               imem_valid;
  logic [soc_bus_pkg::addr_width-1:0] imem_addr;
  logic                               imem_ready;
  logic [soc_bus_pkg::data_width-1:0] imem_rdata;
  logic                               imem_error;
  logic                               dmem_valid;
  logic [soc_bus_pkg::addr_width-1:0] dmem_addr;
  logic [soc_bus_pkg::data_width-1:0] dmem_wdata;
  logic [soc_bus_pkg::strb_width-1:0] dmem_wstrb;
  logic                               dmem_ready;
  logic [soc_bus_pkg::data_width-1:0] dmem_rdata;
  logic                               dmem_error;
  logic                               tx;
  logic                               msip;
  logic                               mtip;

  logic [31:0] patterns [pattern_count * 6];  // six words per transaction
  int errors = 0;
  int data_pos = 0;  // index of the data entry now in progress
  time dmem_ready_time;

  soc_bus dut0 (.*);

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // both request tasks start 1 ns after a rising edge and return at the same point
  task automatic issue_data(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata,
                            output logic error);
    dmem_addr = addr;
    dmem_wdata = wdata;
    dmem_wstrb = strb;
    dmem_valid = 1'b1;
    @(negedge clock);
    while (dmem_ready !== 1'b1) begin
      @(negedge clock);
    end
    rdata = dmem_rdata;
    error = dmem_error;
    dmem_ready_time = $time;
    @(posedge clock);
    #1;
    dmem_valid = 1'b0;
  endtask

  task automatic issue_fetch(input logic [31:0] addr, output logic [31:0] rdata,
                             output logic error);
    imem_addr = addr;
    imem_valid = 1'b1;
    @(negedge clock);
    while (imem_ready !== 1'b1) begin
      @(negedge clock);
    end
    rdata = imem_rdata;
    error = imem_error;
    @(posedge clock);
    #1;
    imem_valid = 1'b0;
  endtask

  task automatic walk_patterns(input logic data_port);
    logic [31:0] rdata;
    logic error;
    int base;
    for (int k = 0; k < pattern_count; k++) begin
      base = 6 * k;
      if (patterns[base][0] == data_port) begin
        if (data_port) begin
          data_pos = k;
        end else begin
          wait (data_pos >= k);  // fetches see every earlier data write
        end
        repeat ($urandom_range(3, 0)) begin
          @(posedge clock);
          #1;
        end
        if (data_port) begin
          issue_data(patterns[base + 1], patterns[base + 2], patterns[base + 3][3:0],
                     rdata, error);
        end else begin
          issue_fetch(patterns[base + 1], rdata, error);
        end
        check_value(rdata, patterns[base + 4], $sformatf("pattern %0d rdata", k));
        check_value(32'(error), patterns[base + 5], $sformatf("pattern %0d error", k));
      end
    end
    if (data_port) begin
      data_pos = pattern_count;
    end
  endtask

  task automatic test_clint();
    logic [31:0] rdata;
    logic [31:0] first_time;
    logic error;
    int compare;
    int waited;
    issue_data(soc_bus_pkg::clint_base_addr, 32'd1, 4'hf, rdata, error);
    check_value(32'(msip), 32'd1, "msip after setting its bit");
    issue_data(soc_bus_pkg::clint_base_addr, 32'd0, 4'hf, rdata, error);
    check_value(32'(msip), 32'd0, "msip after clearing its bit");
    issue_data(soc_bus_pkg::clint_base_addr + 32'hBFF8, 32'd0, 4'h0, first_time, error);
    issue_data(soc_bus_pkg::clint_base_addr + 32'hBFF8, 32'd0, 4'h0, rdata, error);
    check_value(32'(rdata >= first_time), 32'd1, "mtime went backwards");
    compare = int'(rdata) + 20;
    issue_data(soc_bus_pkg::clint_base_addr + 32'h4004, 32'd0, 4'hf, rdata, error);
    check_value(32'(mtip), 32'd0, "mtip with only mtimecmp high cleared");
    issue_data(soc_bus_pkg::clint_base_addr + 32'h4000, 32'(compare), 4'hf, rdata, error);
    check_value(32'(mtip), 32'd0, "mtip right after the compare write");
    waited = 0;
    while (mtip !== 1'b1 && waited < compare * soc_bus_pkg::clint_tick_cycles + 20) begin
      @(negedge clock);
      waited++;
    end
    check_value(32'(mtip), 32'd1, "mtip within the compare time");
    @(posedge clock);
    #1;
  endtask

  // samples each bit near its middle, start bit first and data LSB first
  task automatic receive_frame(output logic [7:0] data, output time fall_time);
    @(negedge tx);
    fall_time = $time;
    repeat (soc_bus_pkg::uart_bit_cycles / 2) @(negedge clock);
    check_value(32'(tx), 32'd0, "uart start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (soc_bus_pkg::uart_bit_cycles) @(negedge clock);
      data[i] = tx;
    end
    repeat (soc_bus_pkg::uart_bit_cycles) @(negedge clock);
    check_value(32'(tx), 32'd1, "uart stop bit");
  endtask

  task automatic test_uart();
    logic [7:0] first_byte;
    logic [7:0] second_byte;
    logic [31:0] rdata;
    logic error;
    time first_fall;
    time second_fall;
    time second_ready;
    time frame_end;
    check_value(32'(tx), 32'd1, "uart line idle before the frames");
    fork
      begin
        receive_frame(first_byte, first_fall);
        receive_frame(second_byte, second_fall);
      end
      begin
        issue_data(soc_bus_pkg::uart_tx_base_addr, 32'hA5, 4'h1, rdata, error);
        issue_data(soc_bus_pkg::uart_tx_base_addr, 32'h3C, 4'h1, rdata, error);
        second_ready = dmem_ready_time;
        issue_data(soc_bus_pkg::uart_tx_base_addr + 32'd4, 32'd0, 4'h0, rdata, error);
        check_value(rdata, 32'd1, "uart status during a frame");
      end
    join
    check_value(32'(first_byte), 32'hA5, "first uart byte");
    check_value(32'(second_byte), 32'h3C, "second uart byte");
    frame_end = first_fall + 64'(10 * soc_bus_pkg::uart_bit_cycles * clock_period);
    check_value(32'(second_ready >= frame_end), 32'd1, "second uart write ready too early");
    check_value(32'(second_fall >= frame_end), 32'd1, "second uart frame began too early");
    repeat (soc_bus_pkg::uart_bit_cycles) @(posedge clock);
    #1;
    issue_data(soc_bus_pkg::uart_tx_base_addr + 32'd4, 32'd0, 4'h0, rdata, error);
    check_value(rdata, 32'd0, "uart status after the frames");
  endtask

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // a ready pulse must always belong to a request that is still pending
  initial begin
    forever begin
      @(negedge clock);
      check_value(32'(imem_ready & ~imem_valid), 32'd0, "instruction ready without request");
      check_value(32'(dmem_ready & ~dmem_valid), 32'd0, "data ready without request");
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("Errors: %0d", errors);
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(seed));
    reset = 1'b0;
    imem_valid = 1'b0;
    imem_addr = '0;
    dmem_valid = 1'b0;
    dmem_addr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    $readmemh("testbench/bus_patterns.txt", patterns);
    if ($isunknown(patterns[0])) begin
      errors++;
      $display("The pattern file testbench/bus_patterns.txt could not be read");
    end
    repeat (8) @(posedge clock);
    #1;
    check_value(32'({imem_ready, dmem_ready, msip, mtip}), 32'd0, "outputs during reset");
    check_value(32'(tx), 32'd1, "tx during reset");
    reset = 1'b1;
    @(posedge clock);
    #1;
    fork
      walk_patterns(1'b0);
      walk_patterns(1'b1);
    join
    test_clint();
    test_uart();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
